// ==== rnn_dense_top.f ====
src/rnn_pkg.sv
src/coef_rd_if.sv
src/coef_store.sv
src/dense_sequencer.sv
src/act_unit.sv
src/rnn_dense_top.sv
verif/tb_rnn_dense_sva.sv
verif/tb_rnn_dense.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dense layer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal -f rnn_dense_top.f \
	--top-module tb_rnn_dense -o sim_rnn_dense &&
./obj_dir/sim_rnn_dense | tee /dev/stderr | grep -F -x "=== PASS ===" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/tb_rnn_dense.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rnn_dense;

	localparam int NI = 42;
	localparam int NN = 24;
	// eight layer runs over all tests with loading inside the slack
	localparam int RUNS = 8;
	localparam int WATCHDOG_CYCLES = 4 * (NI + 1) * NN * RUNS;

	logic              clk;
	logic              rst;
	logic              wr_en_i;
	rnn_pkg::mem_sel_t wr_sel_i;
	rnn_pkg::wr_addr_t wr_addr_i;
	rnn_pkg::fixed_t   wr_data_i;
	logic              start_i;
	rnn_pkg::act_sel_t act_sel_i;
	logic              busy_o;
	logic              gain_valid_o;
	logic [7:0]        gain_idx_o;
	rnn_pkg::fixed_t   gain_o;
	logic              done_o;

	// model copies of what was written into the DUT
	rnn_pkg::fixed_t w_model [NI * NN];
	rnn_pkg::fixed_t b_model [NN];
	rnn_pkg::fixed_t f_model [NI];
	rnn_pkg::fixed_t tbl_model [rnn_pkg::TANH_ENTRIES];

	rnn_pkg::fixed_t exp_q [$];
	rnn_pkg::fixed_t got_gain [NN];
	rnn_pkg::fixed_t prev_gain [NN];
	int              seed = 32'h139f_f5f2;

	rnn_dense_top #(
		.N_INPUTS  (NI),
		.N_NEURONS (NN)
	) dut (
		.clk          (clk),
		.rst          (rst),
		.wr_en_i      (wr_en_i),
		.wr_sel_i     (wr_sel_i),
		.wr_addr_i    (wr_addr_i),
		.wr_data_i    (wr_data_i),
		.start_i      (start_i),
		.act_sel_i    (act_sel_i),
		.busy_o       (busy_o),
		.gain_valid_o (gain_valid_o),
		.gain_idx_o   (gain_idx_o),
		.gain_o       (gain_o),
		.done_o       (done_o)
	);

	bind rnn_dense_top tb_rnn_dense_sva sva (
		.clk          (clk),
		.rst          (rst),
		.busy_i       (busy_o),
		.gain_valid_i (gain_valid_o),
		.gain_idx_i   (gain_idx_o),
		.done_i       (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic string describe_mismatch(input int n, input rnn_pkg::fixed_t expected,
			input rnn_pkg::fixed_t actual);
		return $sformatf("MISMATCH at %0d ns: neuron %0d expected %h got %h",
			$time, n, expected, actual);
	endfunction

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure($sformatf("timeout: tests still running after %0d cycles",
			WATCHDOG_CYCLES));
	end

	task automatic write_word(input rnn_pkg::mem_sel_t sel, input int addr,
			input rnn_pkg::fixed_t data);
		@(negedge clk);
		wr_en_i   = 1'b1;
		wr_sel_i  = sel;
		wr_addr_i = rnn_pkg::wr_addr_t'(addr);
		wr_data_i = data;
		@(negedge clk);
		wr_en_i = 1'b0;
	endtask

	task automatic load_table();
		for (int k = 0; k < rnn_pkg::TANH_ENTRIES; k++) begin
			tbl_model[k] = $rtoi($tanh(real'(k) / 256.0) * 65536.0 + 0.5);
			write_word(rnn_pkg::MEM_TANH, k, tbl_model[k]);
		end
	endtask

	// weights within +-128.0 at address i*NN + n
	task automatic load_weights();
		for (int i = 0; i < NI; i++) begin
			for (int n = 0; n < NN; n++) begin
				w_model[i * NN + n] = $random(seed) % (128 * 65536);
				write_word(rnn_pkg::MEM_WEIGHT, i * NN + n, w_model[i * NN + n]);
			end
		end
	endtask

	// +-12000.0 outweighs any weighted sum so every neuron saturates
	task automatic load_biases(input bit saturate);
		for (int n = 0; n < NN; n++) begin
			if (saturate) begin
				b_model[n] = (n % 2 == 0) ? 12000 * 65536 : -(12000 * 65536);
			end else begin
				b_model[n] = $random(seed) % (64 * 65536);
			end
			write_word(rnn_pkg::MEM_BIAS, n, b_model[n]);
		end
	endtask

	task automatic load_features();
		for (int i = 0; i < NI; i++) begin
			f_model[i] = $random(seed) % 65536;
			write_word(rnn_pkg::MEM_FEATURE, i, f_model[i]);
		end
	endtask

	function automatic rnn_pkg::fixed_t model_gain(input int n, input rnn_pkg::act_sel_t sel);
		rnn_pkg::fixed_t acc;
		rnn_pkg::fixed_t x;
		rnn_pkg::fixed_t m;
		rnn_pkg::fixed_t t;
		rnn_pkg::prod_t  p;
		longint          blend;
		int              k;
		int              fr;
		acc = b_model[n];
		for (int i = 0; i < NI; i++) begin
			p = rnn_pkg::prod_t'(w_model[i * NN + n]) * rnn_pkg::prod_t'(f_model[i]);
			acc = acc + p[47:16];
		end
		x = acc >>> 8;
		if (sel == rnn_pkg::ACT_SIGMOID) begin
			x = x >>> 1;
		end
		m = (x < 0) ? -x : x;
		if ($unsigned(m) >= 32'h0004_0000) begin
			t = rnn_pkg::FX_ONE;
		end else begin
			k = int'(m[17:8]);
			fr = int'(m[7:0]);
			blend = longint'(tbl_model[k]) * (256 - fr)
				+ longint'(tbl_model[(k == 1023) ? k : k + 1]) * fr;
			t = rnn_pkg::fixed_t'(blend >>> 8);
		end
		if (x < 0) begin
			t = -t;
		end
		if (sel == rnn_pkg::ACT_SIGMOID) begin
			return (t >>> 1) + rnn_pkg::FX_HALF;
		end
		return t;
	endfunction

	// one layer run with an optional stray start at cycle restart_at
	task automatic run_layer(input rnn_pkg::act_sel_t sel, input int restart_at);
		int              cyc;
		int              n_gain;
		int              last_gain_cyc;
		bit              done_seen;
		rnn_pkg::fixed_t expected;
		exp_q.delete();
		for (int n = 0; n < NN; n++) begin
			exp_q.push_back(model_gain(n, sel));
		end
		cyc = 0;
		n_gain = 0;
		last_gain_cyc = -1;
		done_seen = 1'b0;
		@(negedge clk);
		start_i   = 1'b1;
		act_sel_i = sel;
		while (!done_seen) begin
			@(negedge clk);
			cyc++;
			start_i = (cyc == restart_at);
			if (gain_valid_o) begin
				assert (n_gain < NN) else stop_with_failure("more gains than neurons in one run");
				// one neuron every bias cycle plus NI multiply cycles
				if (n_gain > 0) begin
					assert (cyc - last_gain_cyc == NI + 1)
						else stop_with_failure($sformatf(
							"MISMATCH at %0d ns: gain %0d came %0d cycles after the last, expected %0d",
							$time, n_gain, cyc - last_gain_cyc, NI + 1));
				end
				expected = exp_q.pop_front();
				assert (gain_idx_o == 8'(n_gain))
					else stop_with_failure($sformatf("MISMATCH at %0d ns: gain index %0d, expected %0d",
						$time, gain_idx_o, n_gain));
				assert (gain_o == expected)
					else stop_with_failure(describe_mismatch(n_gain, expected, gain_o));
				got_gain[n_gain] = gain_o;
				n_gain++;
				last_gain_cyc = cyc;
			end
			if (done_o) begin
				assert (cyc == last_gain_cyc + 1)
					else stop_with_failure("done did not come one cycle after the last gain");
				done_seen = 1'b1;
			end else begin
				assert (busy_o) else stop_with_failure("busy dropped before done");
			end
		end
		assert (n_gain == NN)
			else stop_with_failure($sformatf("MISMATCH at %0d ns: %0d gains, expected %0d",
				$time, n_gain, NN));
		assert (!busy_o) else stop_with_failure("busy still high together with done");
		@(negedge clk);
		assert (!done_o && !busy_o) else stop_with_failure("done held too long or busy came back");
	endtask

	task automatic run_tanh_layer();
		run_layer(rnn_pkg::ACT_TANH, 0);
		prev_gain = got_gain;
	endtask

	task automatic run_sigmoid_layer();
		run_layer(rnn_pkg::ACT_SIGMOID, 0);
		for (int n = 0; n < NN; n++) begin
			assert (got_gain[n] >= 0 && got_gain[n] <= rnn_pkg::FX_ONE)
				else stop_with_failure($sformatf("sigmoid gain of neuron %0d outside 0 to 1.0", n));
		end
	endtask

	// new features only while the old weights stay in the store
	task automatic rerun_with_new_features();
		bit changed;
		load_features();
		run_layer(rnn_pkg::ACT_TANH, 0);
		changed = 1'b0;
		for (int n = 0; n < NN; n++) begin
			if (got_gain[n] != prev_gain[n]) begin
				changed = 1'b1;
			end
		end
		assert (changed) else stop_with_failure("new features left every gain unchanged");
	endtask

	task automatic exercise_start_and_reset();
		run_layer(rnn_pkg::ACT_SIGMOID, 100);
		// reset in the middle of a run while gains are flowing
		@(negedge clk);
		start_i   = 1'b1;
		act_sel_i = rnn_pkg::ACT_TANH;
		@(negedge clk);
		start_i = 1'b0;
		repeat (300) @(negedge clk);
		assert (busy_o) else stop_with_failure("no run in progress before the reset");
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		repeat (20) begin
			assert (!busy_o && !gain_valid_o && !done_o)
				else stop_with_failure("DUT still active after a reset in the middle of a run");
			@(negedge clk);
		end
		run_layer(rnn_pkg::ACT_TANH, 0);
	endtask

	task automatic drive_into_saturation();
		rnn_pkg::fixed_t expected;
		load_biases(1'b1);
		run_layer(rnn_pkg::ACT_TANH, 0);
		for (int n = 0; n < NN; n++) begin
			expected = (n % 2 == 0) ? rnn_pkg::FX_ONE : rnn_pkg::FX_MINUS_ONE;
			assert (got_gain[n] == expected)
				else stop_with_failure(describe_mismatch(n, expected, got_gain[n]));
		end
		run_layer(rnn_pkg::ACT_SIGMOID, 0);
		for (int n = 0; n < NN; n++) begin
			expected = (n % 2 == 0) ? rnn_pkg::FX_ONE : '0;
			assert (got_gain[n] == expected)
				else stop_with_failure(describe_mismatch(n, expected, got_gain[n]));
		end
	endtask

	initial begin
		rst       = 1'b1;
		wr_en_i   = 1'b0;
		wr_sel_i  = rnn_pkg::MEM_WEIGHT;
		wr_addr_i = '0;
		wr_data_i = '0;
		start_i   = 1'b0;
		act_sel_i = rnn_pkg::ACT_TANH;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		assert (!busy_o && !gain_valid_o && !done_o)
			else stop_with_failure("outputs not idle after reset");
		load_table();
		load_weights();
		load_biases(1'b0);
		load_features();
		run_tanh_layer();
		run_sigmoid_layer();
		rerun_with_new_features();
		exercise_start_and_reset();
		drive_into_saturation();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_rnn_dense_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rnn_dense_sva (
	input wire logic       clk,
	input wire logic       rst,
	input wire logic       busy_i,
	input wire logic       gain_valid_i,
	input wire logic [7:0] gain_idx_i,
	input wire logic       done_i
);

	logic [7:0] prev_idx;
	logic       have_prev;

	// index of the previous gain within the current run
	always_ff @(posedge clk) begin
		if (rst || done_i) begin
			have_prev <= 1'b0;
		end else if (gain_valid_i) begin
			have_prev <= 1'b1;
			prev_idx  <= gain_idx_i;
		end
	end

	gain_only_while_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(gain_valid_i) |-> busy_i)
		else $error("gain_valid rose while busy was low");

	done_single_pulse: assert property (@(posedge clk) disable iff (rst)
		done_i |=> !done_i)
		else $error("done stayed high for more than one cycle");

	gain_idx_steps: assert property (@(posedge clk) disable iff (rst)
		(gain_valid_i && have_prev) |-> (gain_idx_i == prev_idx + 8'd1))
		else $error("gain index did not step by one between gains");

endmodule

`default_nettype wire

// ==== src/rnn_dense_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_dense_top #(
	parameter int N_INPUTS  = 42,
	parameter int N_NEURONS = 24
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               wr_en_i,
	input  wire rnn_pkg::mem_sel_t  wr_sel_i,
	input  wire rnn_pkg::wr_addr_t  wr_addr_i,
	input  wire rnn_pkg::fixed_t    wr_data_i,
	input  wire logic               start_i,
	input  wire rnn_pkg::act_sel_t  act_sel_i,
	output logic                    busy_o,
	output logic                    gain_valid_o,
	output logic [7:0]              gain_idx_o,
	output rnn_pkg::fixed_t         gain_o,
	output logic                    done_o
);

	coef_rd_if #(
		.N_INPUTS  (N_INPUTS),
		.N_NEURONS (N_NEURONS)
	) rd_if ();

	logic               acc_valid;
	rnn_pkg::fixed_t    acc;
	logic [7:0]         acc_idx;
	logic               acc_last;
	rnn_pkg::act_sel_t  act_sel;
	rnn_pkg::tanh_idx_t tbl_addr;
	rnn_pkg::fixed_t    tbl_lo;
	rnn_pkg::fixed_t    tbl_hi;
	logic               gain_last;

	coef_store #(
		.N_INPUTS  (N_INPUTS),
		.N_NEURONS (N_NEURONS)
	) u_store (
		.clk        (clk),
		.wr_en_i    (wr_en_i),
		.wr_sel_i   (wr_sel_i),
		.wr_addr_i  (wr_addr_i),
		.wr_data_i  (wr_data_i),
		.rd         (rd_if),
		.tbl_addr_i (tbl_addr),
		.tbl_lo_o   (tbl_lo),
		.tbl_hi_o   (tbl_hi)
	);

	dense_sequencer #(
		.N_INPUTS  (N_INPUTS),
		.N_NEURONS (N_NEURONS)
	) u_seq (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start_i),
		.act_sel_i   (act_sel_i),
		.rd          (rd_if),
		.busy_o      (busy_o),
		.acc_valid_o (acc_valid),
		.acc_o       (acc),
		.idx_o       (acc_idx),
		.last_o      (acc_last),
		.act_sel_o   (act_sel)
	);

	act_unit u_act (
		.clk          (clk),
		.rst          (rst),
		.acc_valid_i  (acc_valid),
		.acc_i        (acc),
		.idx_i        (acc_idx),
		.last_i       (acc_last),
		.act_sel_i    (act_sel),
		.tbl_addr_o   (tbl_addr),
		.tbl_lo_i     (tbl_lo),
		.tbl_hi_i     (tbl_hi),
		.gain_valid_o (gain_valid_o),
		.gain_o       (gain_o),
		.gain_idx_o   (gain_idx_o),
		.last_o       (gain_last)
	);

	// done one cycle after the last gain, as busy drops
	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= gain_last;
		end
	end

endmodule

`default_nettype wire

// ==== src/act_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module act_unit (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                acc_valid_i,
	input  wire rnn_pkg::fixed_t     acc_i,
	input  wire logic [7:0]          idx_i,
	input  wire logic                last_i,
	input  wire rnn_pkg::act_sel_t   act_sel_i,
	output rnn_pkg::tanh_idx_t       tbl_addr_o,
	input  wire rnn_pkg::fixed_t     tbl_lo_i,
	input  wire rnn_pkg::fixed_t     tbl_hi_i,
	output logic                     gain_valid_o,
	output rnn_pkg::fixed_t          gain_o,
	output logic [7:0]               gain_idx_o,
	output logic                     last_o
);

	localparam int FRAC_W = $bits(rnn_pkg::interp_frac_t);

	rnn_pkg::fixed_t scaled;
	rnn_pkg::fixed_t x;
	rnn_pkg::fixed_t mag;
	logic            sat;

	logic                  s1_valid, s1_last, s1_neg, s1_sat;
	logic [7:0]            s1_idx;
	rnn_pkg::act_sel_t     s1_sel;
	rnn_pkg::interp_frac_t s1_frac;

	logic                  s2_valid, s2_last, s2_neg, s2_sat;
	logic [7:0]            s2_idx;
	rnn_pkg::act_sel_t     s2_sel;
	rnn_pkg::interp_frac_t s2_frac;

	rnn_pkg::prod_t  wt_hi;
	rnn_pkg::prod_t  wt_lo;
	rnn_pkg::prod_t  interp;
	rnn_pkg::fixed_t t_mag;
	rnn_pkg::fixed_t t;
	rnn_pkg::fixed_t gain_next;

	// stage 1: scale, sigmoid halving, sign and magnitude
	always_comb begin
		scaled = acc_i >>> rnn_pkg::WEIGHT_SHIFT;
		x      = (act_sel_i == rnn_pkg::ACT_SIGMOID) ? (scaled >>> 1) : scaled;
		mag    = x[31] ? -x : x;
		sat    = |mag[31:rnn_pkg::TANH_SAT_BIT];
	end

	always_ff @(posedge clk) begin
		tbl_addr_o <= mag[rnn_pkg::TANH_SAT_BIT-1:FRAC_W];
		s1_frac    <= mag[FRAC_W-1:0];
		s1_neg     <= x[31];
		s1_sat     <= sat;
		s1_idx     <= idx_i;
		s1_last    <= last_i;
		s1_sel     <= act_sel_i;
	end

	// stage 2: table read in flight in the store
	always_ff @(posedge clk) begin
		s2_frac <= s1_frac;
		s2_neg  <= s1_neg;
		s2_sat  <= s1_sat;
		s2_idx  <= s1_idx;
		s2_last <= s1_last;
		s2_sel  <= s1_sel;
	end

	// stage 3: each entry weighted by its distance from the other
	always_comb begin
		wt_hi  = rnn_pkg::prod_t'(s2_frac);
		wt_lo  = rnn_pkg::prod_t'(1 << FRAC_W) - wt_hi;
		interp = rnn_pkg::prod_t'(tbl_lo_i) * wt_lo + rnn_pkg::prod_t'(tbl_hi_i) * wt_hi;
		t_mag  = s2_sat ? rnn_pkg::FX_ONE : rnn_pkg::fixed_t'(interp >>> FRAC_W);
		t      = s2_neg ? -t_mag : t_mag;
		if (s2_sel == rnn_pkg::ACT_SIGMOID) begin
			gain_next = (t >>> 1) + rnn_pkg::FX_HALF;
		end else begin
			gain_next = t;
		end
	end

	always_ff @(posedge clk) begin
		gain_o     <= gain_next;
		gain_idx_o <= s2_idx;
	end

	// valid and last markers
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid     <= 1'b0;
			s2_valid     <= 1'b0;
			gain_valid_o <= 1'b0;
			last_o       <= 1'b0;
		end else begin
			s1_valid     <= acc_valid_i;
			s2_valid     <= s1_valid;
			gain_valid_o <= s2_valid;
			last_o       <= s2_valid & s2_last;
		end
	end

endmodule

`default_nettype wire

// ==== src/dense_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dense_sequencer #(
	parameter int N_INPUTS  = 42,
	parameter int N_NEURONS = 24
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               start_i,
	input  wire rnn_pkg::act_sel_t  act_sel_i,
	coef_rd_if.seq                  rd,
	output logic                    busy_o,
	output logic                    acc_valid_o,
	output rnn_pkg::fixed_t         acc_o,
	output logic [7:0]              idx_o,
	output logic                    last_o,
	output rnn_pkg::act_sel_t       act_sel_o
);

	localparam int W_AW = $clog2(N_INPUTS * N_NEURONS);
	localparam int B_AW = $clog2(N_NEURONS);
	localparam int F_AW = $clog2(N_INPUTS);

	// last accumulator to done: 3 pipeline stages plus the done register
	localparam int DRAIN_CYCLES = 4;

	rnn_pkg::seq_state_t state;
	logic [B_AW-1:0]     neuron;
	logic [F_AW-1:0]     in_cnt;
	logic [1:0]          drain_cnt;
	logic [W_AW-1:0]     w_ptr;
	logic [F_AW-1:0]     f_ptr;
	logic [B_AW-1:0]     b_ptr;
	rnn_pkg::prod_t      prod;
	logic                last_input;
	logic                last_neuron;

	assign busy_o = (state != rnn_pkg::IDLE);

	// addresses run one cycle ahead of the data they fetch
	assign rd.w_addr = w_ptr;
	assign rd.f_addr = f_ptr;
	assign rd.b_addr = b_ptr;

	assign last_input  = (int'(in_cnt) == N_INPUTS - 1);
	assign last_neuron = (int'(neuron) == N_NEURONS - 1);

	assign prod = rd.w_data * rd.f_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= rnn_pkg::IDLE;
			neuron      <= '0;
			in_cnt      <= '0;
			drain_cnt   <= '0;
			w_ptr       <= '0;
			f_ptr       <= '0;
			b_ptr       <= '0;
			acc_valid_o <= 1'b0;
			last_o      <= 1'b0;
			act_sel_o   <= rnn_pkg::ACT_TANH;
		end else begin
			acc_valid_o <= 1'b0;
			last_o      <= 1'b0;
			case (state)
				rnn_pkg::IDLE: begin
					w_ptr <= '0;
					f_ptr <= '0;
					b_ptr <= '0;
					if (start_i) begin
						state     <= rnn_pkg::BIAS;
						neuron    <= '0;
						act_sel_o <= act_sel_i;
					end
				end
				rnn_pkg::BIAS: begin
					state  <= rnn_pkg::MAC;
					in_cnt <= '0;
					w_ptr  <= w_ptr + W_AW'(N_NEURONS);
					f_ptr  <= f_ptr + 1'b1;
					// next neuron's bias is fetched during the last MAC
					b_ptr  <= b_ptr + 1'b1;
				end
				rnn_pkg::MAC: begin
					if (last_input) begin
						acc_valid_o <= 1'b1;
						last_o      <= last_neuron;
						w_ptr       <= W_AW'(neuron) + 1'b1;
						f_ptr       <= '0;
						if (last_neuron) begin
							state     <= rnn_pkg::DRAIN;
							drain_cnt <= '0;
						end else begin
							state  <= rnn_pkg::BIAS;
							neuron <= neuron + 1'b1;
						end
					end else begin
						in_cnt <= in_cnt + 1'b1;
						w_ptr  <= w_ptr + W_AW'(N_NEURONS);
						f_ptr  <= f_ptr + 1'b1;
					end
				end
				rnn_pkg::DRAIN: begin
					// park the pointers for the next run
					w_ptr <= '0;
					f_ptr <= '0;
					b_ptr <= '0;
					if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
						state <= rnn_pkg::IDLE;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					state <= rnn_pkg::IDLE;
				end
			endcase
		end
	end

	// accumulator, wraps in 32 bits
	always_ff @(posedge clk) begin
		if (state == rnn_pkg::BIAS) begin
			acc_o <= rd.b_data;
		end else if (state == rnn_pkg::MAC) begin
			acc_o <= acc_o + prod[47:16];
			if (last_input) begin
				idx_o <= 8'(neuron);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/coef_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_store #(
	parameter int N_INPUTS  = 42,
	parameter int N_NEURONS = 24
) (
	input  wire logic                clk,
	input  wire logic                wr_en_i,
	input  wire rnn_pkg::mem_sel_t   wr_sel_i,
	input  wire rnn_pkg::wr_addr_t   wr_addr_i,
	input  wire rnn_pkg::fixed_t     wr_data_i,
	coef_rd_if.store                 rd,
	input  wire rnn_pkg::tanh_idx_t  tbl_addr_i,
	output rnn_pkg::fixed_t          tbl_lo_o,
	output rnn_pkg::fixed_t          tbl_hi_o
);

	localparam int W_DEPTH = N_INPUTS * N_NEURONS;
	localparam int W_AW    = $clog2(W_DEPTH);
	localparam int B_AW    = $clog2(N_NEURONS);
	localparam int F_AW    = $clog2(N_INPUTS);

	// weight for input i and neuron n at i*N_NEURONS + n
	rnn_pkg::fixed_t w_mem [W_DEPTH];
	rnn_pkg::fixed_t b_mem [N_NEURONS];
	rnn_pkg::fixed_t f_mem [N_INPUTS];
	rnn_pkg::fixed_t tanh_mem [rnn_pkg::TANH_ENTRIES];

	rnn_pkg::tanh_idx_t tbl_next;
	logic               wr_in_range;

	// drop writes past the end of the chosen memory
	always_comb begin
		case (wr_sel_i)
			rnn_pkg::MEM_WEIGHT:  wr_in_range = int'(wr_addr_i) < W_DEPTH;
			rnn_pkg::MEM_BIAS:    wr_in_range = int'(wr_addr_i) < N_NEURONS;
			rnn_pkg::MEM_FEATURE: wr_in_range = int'(wr_addr_i) < N_INPUTS;
			default:              wr_in_range = int'(wr_addr_i) < rnn_pkg::TANH_ENTRIES;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_en_i && wr_in_range) begin
			case (wr_sel_i)
				rnn_pkg::MEM_WEIGHT: begin
					w_mem[wr_addr_i[W_AW-1:0]] <= wr_data_i;
				end
				rnn_pkg::MEM_BIAS: begin
					b_mem[wr_addr_i[B_AW-1:0]] <= wr_data_i;
				end
				rnn_pkg::MEM_FEATURE: begin
					f_mem[wr_addr_i[F_AW-1:0]] <= wr_data_i;
				end
				default: begin
					tanh_mem[rnn_pkg::tanh_idx_t'(wr_addr_i)] <= wr_data_i;
				end
			endcase
		end
	end

	// coefficient reads for the sequencer
	always_ff @(posedge clk) begin
		rd.w_data <= w_mem[rd.w_addr];
		rd.b_data <= b_mem[rd.b_addr];
		rd.f_data <= f_mem[rd.f_addr];
	end

	// upper neighbour clamps at the last entry
	always_comb begin
		if (int'(tbl_addr_i) == rnn_pkg::TANH_ENTRIES - 1) begin
			tbl_next = tbl_addr_i;
		end else begin
			tbl_next = tbl_addr_i + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		tbl_lo_o <= tanh_mem[tbl_addr_i];
		tbl_hi_o <= tanh_mem[tbl_next];
	end

endmodule

`default_nettype wire

// ==== src/coef_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface coef_rd_if #(
	parameter int N_INPUTS  = 42,
	parameter int N_NEURONS = 24
);

	localparam int W_AW = $clog2(N_INPUTS * N_NEURONS);
	localparam int B_AW = $clog2(N_NEURONS);
	localparam int F_AW = $clog2(N_INPUTS);

	// read data lands one cycle after the address
	logic [W_AW-1:0] w_addr;
	rnn_pkg::fixed_t w_data;
	logic [B_AW-1:0] b_addr;
	rnn_pkg::fixed_t b_data;
	logic [F_AW-1:0] f_addr;
	rnn_pkg::fixed_t f_data;

	modport seq (
		output w_addr, b_addr, f_addr,
		input  w_data, b_data, f_data
	);

	modport store (
		input  w_addr, b_addr, f_addr,
		output w_data, b_data, f_data
	);

endinterface

`default_nettype wire

// ==== src/rnn_pkg.sv ====
`default_nettype none

package rnn_pkg;

	// signed Q16.16
	typedef logic signed [31:0] fixed_t;

	// full product of two Q16.16 values, back to fixed_t via [47:16]
	typedef logic signed [63:0] prod_t;

	typedef logic [9:0] tanh_idx_t;
	typedef logic [7:0] interp_frac_t;
	typedef logic [15:0] wr_addr_t;

	// write port memory select
	typedef logic [1:0] mem_sel_t;

	localparam mem_sel_t MEM_WEIGHT  = 2'd0;
	localparam mem_sel_t MEM_BIAS    = 2'd1;
	localparam mem_sel_t MEM_FEATURE = 2'd2;
	localparam mem_sel_t MEM_TANH    = 2'd3;

	// activation choice
	typedef logic act_sel_t;

	localparam act_sel_t ACT_TANH    = 1'b0;
	localparam act_sel_t ACT_SIGMOID = 1'b1;

	typedef enum logic [1:0] {
		IDLE,
		BIAS,
		MAC,
		DRAIN
	} seq_state_t;

	localparam fixed_t FX_ONE       = 32'sh0001_0000;
	localparam fixed_t FX_HALF      = 32'sh0000_8000;
	localparam fixed_t FX_MINUS_ONE = 32'shFFFF_0000;

	// accumulator scale of 1/256
	localparam fixed_t WEIGHT_SHIFT = 32'sd8;

	// entry k holds tanh(k/256)
	localparam int TANH_ENTRIES = 1024;

	// magnitude at or above 4.0 saturates
	localparam int TANH_SAT_BIT = 18;

endpackage

`default_nettype wire
